/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Hardware threads per core
`define THR_PER_CORE        4
`define THR_ID_WIDTH        2

// Address and instruction widths
`define PC_WIDTH            32
`define INSTR_WIDTH         32

// I$ refill line, four instructions
`define ICACHE_LINE_WIDTH   128
// Byte offset inside one line
`define LINE_OFFSET_BITS    4

// Entry point of the exception handler
`define CORE_XCPT_ADDRESS   32'h0000_2000

`endif

/* logic/core_types_pkg.sv */
`default_nettype none

`include "core_cfg.svh"

package core_types_pkg;

    //////////////////////////////////////////////////
    // Core-internal vector types

    // Fetch address
    typedef logic [`PC_WIDTH-1:0]                       pc_t;

    // One instruction word
    typedef logic [`INSTR_WIDTH-1:0]                    instr_t;

    // Thread number and one-bit-per-thread mask
    typedef logic [`THR_ID_WIDTH-1:0]                   thread_id_t;
    typedef logic [`THR_PER_CORE-1:0]                   thread_mask_t;

    // Full refill line
    typedef logic [`ICACHE_LINE_WIDTH-1:0]              line_t;

    // Upper PC bits, used as tag and miss address
    typedef logic [`PC_WIDTH-`LINE_OFFSET_BITS-1:0]     line_addr_t;

endpackage

`default_nettype wire

/* logic/fetch_if_pkg.sv */
`default_nettype none

package fetch_if_pkg;
    import core_types_pkg::*;

    //////////////////////////////////////////////////
    // Memory side

    // I$ miss towards the memory hierarchy
    typedef struct packed {
        line_addr_t     addr;
        thread_id_t     thread_id;
    } memory_request_t;

    // Shared response bus, cache id 0 is the I$, 1 the D$
    typedef struct packed {
        logic           valid;
        logic           cache_id;
        thread_id_t     thread_id;
        logic           bus_error;
        line_t          data;
    } memory_response_t;

    //////////////////////////////////////////////////
    // Pipeline side

    // Branch from the ALU and exception from write-back
    typedef struct packed {
        logic           branch_valid;
        thread_id_t     branch_thread;
        pc_t            branch_pc;
        logic           xcpt_valid;
        thread_id_t     xcpt_thread;
    } redirect_t;

    // Instruction handed to decode
    typedef struct packed {
        logic           valid;
        logic           xcpt;
        thread_id_t     thread_id;
        pc_t            pc;
        instr_t         instr;
    } fetch_out_t;

endpackage

`default_nettype wire

/* logic/fetch_miss_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_cfg.svh"

module fetch_miss_fsm
    import core_types_pkg::*;
    import fetch_if_pkg::*;
(
    input  logic                clock,
    input  logic                reset,

    // Miss seen by the PC stage
    input  logic                fetch_miss,
    input  thread_id_t          miss_thread,
    input  pc_t                 miss_pc,

    // Memory hierarchy
    input  memory_response_t    mem_rsp,
    output logic                req_valid,
    output memory_request_t     req_info,

    // Thread waiting on its line
    output thread_mask_t        busy_mask,

    // Refill to the line buffer
    output logic                fill_valid,
    output thread_id_t          fill_thread,
    output line_addr_t          fill_addr,
    output line_t               fill_data,

    // Fetch-side bus error
    output logic                bus_error,
    output thread_id_t          error_thread
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait_rsp,
        st_fill
    } miss_state_e;

    miss_state_e    state_q;
    miss_state_e    state_d;

    // Outstanding miss
    thread_id_t     thread_q;
    line_addr_t     line_q;
    line_t          data_q;
    logic           rsp_accept;

    // Only I$ responses for our own thread
    assign rsp_accept = (state_q == st_wait_rsp) && mem_rsp.valid && !mem_rsp.cache_id
                        && (mem_rsp.thread_id == thread_q);

    //////////////////////////////////////////////////
    // Next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            // Misses arriving while busy are dropped
            st_idle:     if (fetch_miss) state_d = st_request;
            st_request:  state_d = st_wait_rsp;
            // Error goes straight back, no fill
            st_wait_rsp: if (rsp_accept) state_d = mem_rsp.bus_error ? st_idle : st_fill;
            st_fill:     state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    // Capture miss address and returned line
    always_ff @(posedge clock)
    begin
        if (state_q == st_idle && fetch_miss)
        begin
            thread_q <= miss_thread;
            line_q   <= miss_pc[`PC_WIDTH-1:`LINE_OFFSET_BITS];
        end
        if (rsp_accept)
            data_q <= mem_rsp.data;
    end

    //////////////////////////////////////////////////
    // Outputs

    // One-cycle request pulse
    assign req_valid          = (state_q == st_request);
    assign req_info.addr      = line_q;
    assign req_info.thread_id = thread_q;

    // Busy until the fill has been written
    always_comb
    begin
        for (int i = 0; i < `THR_PER_CORE; i++)
            busy_mask[i] = (state_q != st_idle) && (thread_q == thread_id_t'(i));
    end

    assign fill_valid   = (state_q == st_fill);
    assign fill_thread  = thread_q;
    assign fill_addr    = line_q;
    assign fill_data    = data_q;

    assign bus_error    = rsp_accept && mem_rsp.bus_error;
    assign error_thread = thread_q;

endmodule

`default_nettype wire

/* logic/fetch_pc_stage.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_cfg.svh"

module fetch_pc_stage
    import core_types_pkg::*;
    import fetch_if_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    input  pc_t             boot_addr,
    input  redirect_t       redirect,

    // Selected thread
    input  logic            sel_valid,
    input  thread_id_t      sel_thread,

    // Line buffer lookup
    input  logic            hit,
    input  instr_t          instr,

    // Bus error from the miss FSM
    input  logic            bus_error,
    input  thread_id_t      error_thread,

    output pc_t             sel_pc,

    // Miss towards the FSM
    output logic            fetch_miss,
    output thread_id_t      miss_thread,
    output pc_t             miss_pc,

    output thread_mask_t    halted,
    output fetch_out_t      decode_out
);

    pc_t [`THR_PER_CORE-1:0]    pc_q;
    thread_mask_t               halted_q;

    // Redirect decoded per thread
    thread_mask_t   xcpt_mask;
    thread_mask_t   branch_mask;
    thread_mask_t   redir_mask;

    logic           sel_redirected;
    logic           fetch_ok;
    fetch_out_t     decode_d;
    fetch_out_t     decode_q;

    //////////////////////////////////////////////////
    // Redirect decode, exception before branch
    always_comb
    begin
        for (int i = 0; i < `THR_PER_CORE; i++)
        begin
            xcpt_mask[i]   = redirect.xcpt_valid && (redirect.xcpt_thread == thread_id_t'(i));
            branch_mask[i] = redirect.branch_valid
                             && (redirect.branch_thread == thread_id_t'(i));
        end
        redir_mask = xcpt_mask | branch_mask;
    end

    assign sel_pc         = pc_q[sel_thread];
    assign sel_redirected = redir_mask[sel_thread];

    // A bus error owns the output slot this cycle
    // The hit thread simply fetches again later
    assign fetch_ok    = sel_valid && hit && !sel_redirected && !bus_error;
    assign fetch_miss  = sel_valid && !hit && !sel_redirected;
    assign miss_thread = sel_thread;
    assign miss_pc     = sel_pc;

    //////////////////////////////////////////////////
    // Per-thread PC
    always_ff @(posedge clock)
    begin
        for (int i = 0; i < `THR_PER_CORE; i++)
        begin
            if (reset)
                pc_q[i] <= boot_addr;
            else if (xcpt_mask[i])
                pc_q[i] <= `CORE_XCPT_ADDRESS;
            else if (branch_mask[i])
                pc_q[i] <= redirect.branch_pc;
            else if (fetch_ok && sel_thread == thread_id_t'(i))
                pc_q[i] <= pc_q[i] + 32'd4;
        end
    end

    // Halt on bus error until the handler is entered
    always_ff @(posedge clock)
    begin
        if (reset)
            halted_q <= '0;
        else
        begin
            for (int i = 0; i < `THR_PER_CORE; i++)
            begin
                if (xcpt_mask[i])
                    halted_q[i] <= 1'b0;
                else if (bus_error && error_thread == thread_id_t'(i))
                    halted_q[i] <= 1'b1;
            end
        end
    end

    assign halted = halted_q;

    //////////////////////////////////////////////////
    // Registered decode output

    // Exception entry carries no instruction
    always_comb
    begin
        decode_d.valid     = fetch_ok || bus_error;
        decode_d.xcpt      = bus_error;
        decode_d.thread_id = bus_error ? error_thread : sel_thread;
        decode_d.pc        = bus_error ? pc_q[error_thread] : sel_pc;
        decode_d.instr     = bus_error ? '0 : instr;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            decode_q.valid <= 1'b0;
        else
            decode_q.valid <= decode_d.valid;
    end

    // Payload
    always_ff @(posedge clock)
    begin
        decode_q.xcpt      <= decode_d.xcpt;
        decode_q.thread_id <= decode_d.thread_id;
        decode_q.pc        <= decode_d.pc;
        decode_q.instr     <= decode_d.instr;
    end

    assign decode_out = decode_q;

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_top
    import core_types_pkg::*;
    import fetch_if_pkg::*;
(
    // System signals
    input  logic                clock,
    input  logic                reset,

    input  pc_t                 boot_addr,

    // Branch and exception redirect
    input  redirect_t           redirect,

    // Per-thread back-pressure level
    input  thread_mask_t        stall,

    // Response from the memory hierarchy
    input  memory_response_t    mem_rsp,

    // Fetched instruction to decode
    output fetch_out_t          decode_out,

    // I$ miss request
    output logic                icache_req_valid_miss,
    output memory_request_t     icache_req_info_miss
);

    // Selector to PC stage
    logic           sel_valid;
    thread_id_t     sel_thread;
    pc_t            sel_pc;

    // Lookup result
    logic           hit;
    instr_t         instr;

    // Miss path
    logic           fetch_miss;
    thread_id_t     miss_thread;
    pc_t            miss_pc;
    thread_mask_t   halted;
    thread_mask_t   busy_mask;

    // Refill and error
    logic           fill_valid;
    thread_id_t     fill_thread;
    line_addr_t     fill_addr;
    line_t          fill_data;
    logic           bus_error;
    thread_id_t     error_thread;

    //////////////////////////////////////////////////
    // Thread selection
    thread_select_rr
    thread_select_rr
    (
        .clock          ( clock         ),
        .reset          ( reset         ),
        .stall          ( stall         ),
        .halted         ( halted        ),
        .busy_mask      ( busy_mask     ),
        .sel_valid      ( sel_valid     ),
        .sel_thread     ( sel_thread    )
    );

    //////////////////////////////////////////////////
    // PC registers and decode output
    fetch_pc_stage
    fetch_pc_stage
    (
        .clock          ( clock         ),
        .reset          ( reset         ),
        .boot_addr      ( boot_addr     ),
        .redirect       ( redirect      ),
        .sel_valid      ( sel_valid     ),
        .sel_thread     ( sel_thread    ),
        .hit            ( hit           ),
        .instr          ( instr         ),
        .bus_error      ( bus_error     ),
        .error_thread   ( error_thread  ),
        .sel_pc         ( sel_pc        ),
        .fetch_miss     ( fetch_miss    ),
        .miss_thread    ( miss_thread   ),
        .miss_pc        ( miss_pc       ),
        .halted         ( halted        ),
        .decode_out     ( decode_out    )
    );

    // Per-thread line storage
    icache_line_buffer
    icache_line_buffer
    (
        .clock          ( clock         ),
        .reset          ( reset         ),
        .sel_thread     ( sel_thread    ),
        .sel_pc         ( sel_pc        ),
        .fill_valid     ( fill_valid    ),
        .fill_thread    ( fill_thread   ),
        .fill_addr      ( fill_addr     ),
        .fill_data      ( fill_data     ),
        .hit            ( hit           ),
        .instr          ( instr         )
    );

    //////////////////////////////////////////////////
    // Miss handling, D$ responses filtered inside
    fetch_miss_fsm
    fetch_miss_fsm
    (
        .clock          ( clock                 ),
        .reset          ( reset                 ),
        .fetch_miss     ( fetch_miss            ),
        .miss_thread    ( miss_thread           ),
        .miss_pc        ( miss_pc               ),
        .mem_rsp        ( mem_rsp               ),
        .req_valid      ( icache_req_valid_miss ),
        .req_info       ( icache_req_info_miss  ),
        .busy_mask      ( busy_mask             ),
        .fill_valid     ( fill_valid            ),
        .fill_thread    ( fill_thread           ),
        .fill_addr      ( fill_addr             ),
        .fill_data      ( fill_data             ),
        .bus_error      ( bus_error             ),
        .error_thread   ( error_thread          )
    );

endmodule

`default_nettype wire

/* logic/icache_line_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_cfg.svh"

module icache_line_buffer
    import core_types_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    // Lookup from the PC stage
    input  thread_id_t      sel_thread,
    input  pc_t             sel_pc,

    // Refill from the miss FSM
    input  logic            fill_valid,
    input  thread_id_t      fill_thread,
    input  line_addr_t      fill_addr,
    input  line_t           fill_data,

    // Lookup result
    output logic            hit,
    output instr_t          instr
);

    // Word index bits inside a line
    localparam int WORD_BITS = `LINE_OFFSET_BITS - 2;

    // One line per thread
    thread_mask_t                       valid_q;
    line_addr_t [`THR_PER_CORE-1:0]     tag_q;
    line_t      [`THR_PER_CORE-1:0]     data_q;

    line_addr_t             tag_rd;
    line_t                  line_rd;
    logic [WORD_BITS-1:0]   word_sel;

    //////////////////////////////////////////////////
    // Lookup

    assign tag_rd   = tag_q[sel_thread];
    assign line_rd  = data_q[sel_thread];
    // Byte offset drops the two low bits
    assign word_sel = sel_pc[`LINE_OFFSET_BITS-1:2];

    // Tag is the line-aligned part of the PC
    assign hit   = valid_q[sel_thread] && (tag_rd == sel_pc[`PC_WIDTH-1:`LINE_OFFSET_BITS]);
    // Word 0 sits in the low bits
    assign instr = line_rd[word_sel*`INSTR_WIDTH +: `INSTR_WIDTH];

    //////////////////////////////////////////////////
    // Refill

    // Valid bits, cleared on reset
    always_ff @(posedge clock)
    begin
        if (reset)
            valid_q <= '0;
        else if (fill_valid)
            valid_q[fill_thread] <= 1'b1;
    end

    // Tag and data storage
    always_ff @(posedge clock)
    begin
        if (fill_valid)
        begin
            tag_q[fill_thread]  <= fill_addr;
            data_q[fill_thread] <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* logic/thread_select_rr.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_cfg.svh"

module thread_select_rr
    import core_types_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    // Per-thread blocking conditions
    input  thread_mask_t    stall,
    input  thread_mask_t    halted,
    input  thread_mask_t    busy_mask,

    // Thread fetched this cycle
    output logic            sel_valid,
    output thread_id_t      sel_thread
);

    // Last served thread
    thread_id_t     last_q;
    thread_mask_t   eligible;

    assign eligible = ~(stall | halted | busy_mask);

    //////////////////////////////////////////////////
    // Search starting after the last served thread
    always_comb
    begin
        thread_id_t cand;

        cand       = last_q;
        sel_valid  = 1'b0;
        sel_thread = last_q;
        for (int k = 1; k <= `THR_PER_CORE; k++)
        begin
            // Wraps around the thread count
            cand = thread_id_t'((int'(last_q) + k) % `THR_PER_CORE);
            if (!sel_valid && eligible[cand])
            begin
                sel_valid  = 1'b1;
                sel_thread = cand;
            end
        end
    end

    // Pointer only moves on a real pick
    // Starts at the last thread so thread 0 goes first
    always_ff @(posedge clock)
    begin
        if (reset)
            last_q <= thread_id_t'(`THR_PER_CORE - 1);
        else if (sel_valid)
            last_q <= sel_thread;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/core_types_pkg.sv
logic/fetch_if_pkg.sv
logic/thread_select_rr.sv
logic/icache_line_buffer.sv
logic/fetch_miss_fsm.sv
logic/fetch_pc_stage.sv
logic/fetch_top.sv
tb/tb_fetch_top.sv

/* tb/tb_fetch_top.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_cfg.svh"

module tb_fetch_top
    import core_types_pkg::*;
    import fetch_if_pkg::*;
();

    // Five phases of about 400 cycles plus margin
    localparam int CYCLE_LIMIT = 4000;
    localparam pc_t BOOT_PC    = 32'h0000_1000;

    logic               clock;
    logic               reset;
    pc_t                boot_addr;
    redirect_t          redirect;
    thread_mask_t       stall;
    memory_response_t   mem_rsp;
    fetch_out_t         decode_out;
    logic               icache_req_valid_miss;
    memory_request_t    icache_req_info_miss;

    // Reference model of each thread
    pc_t            exp_pc [`THR_PER_CORE];
    logic           halted_model [`THR_PER_CORE];
    logic           err_expected [`THR_PER_CORE];
    logic           xcpt_seen [`THR_PER_CORE];
    logic           redir_pending [`THR_PER_CORE];
    logic           redir_xcpt [`THR_PER_CORE];
    pc_t            redir_target [`THR_PER_CORE];
    int             window_outputs [`THR_PER_CORE];
    thread_mask_t   stall_prev;

    // Memory model state
    logic           outstanding;
    int             countdown;
    line_addr_t     pend_addr;
    thread_id_t     pend_thread;
    line_addr_t     error_lines [$];

    int             phase;
    int             last_phase;
    int             phase_cycles;
    int             cycle_count;
    int             error_count;
    int             output_count;
    int             request_count;
    int             foreign_count;

    fetch_top dut0
    (
        .clock                  ( clock                 ),
        .reset                  ( reset                 ),
        .boot_addr              ( boot_addr             ),
        .redirect               ( redirect              ),
        .stall                  ( stall                 ),
        .mem_rsp                ( mem_rsp               ),
        .decode_out             ( decode_out            ),
        .icache_req_valid_miss  ( icache_req_valid_miss ),
        .icache_req_info_miss   ( icache_req_info_miss  )
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Reporting

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("Error: %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    // Request is a single-cycle pulse
    single_cycle_request: assert property (@(posedge clock) disable iff (reset)
        icache_req_valid_miss |=> !icache_req_valid_miss)
        else report_failure("Miss request stayed high for more than one cycle");

    //////////////////////////////////////////////////
    // Memory model

    function automatic line_t build_line(input line_addr_t addr);
        line_t data;
        for (int i = 0; i < 4; i++)
            data[i*32 +: 32] = {addr, 4'h0} + 32'(4 * i);
        return data;
    endfunction

    function automatic logic is_error_line(input line_addr_t addr);
        foreach (error_lines[i])
            if (error_lines[i] == addr)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic respond_memory();
        logic sent;
        sent    = 1'b0;
        mem_rsp = '0;
        if (outstanding)
        begin
            countdown--;
            if (countdown == 0)
            begin
                mem_rsp.valid     = 1'b1;
                mem_rsp.thread_id = pend_thread;
                mem_rsp.bus_error = is_error_line(pend_addr);
                mem_rsp.data      = build_line(pend_addr);
                if (mem_rsp.bus_error)
                    err_expected[pend_thread] = 1'b1;
                outstanding = 1'b0;
                sent        = 1'b1;
            end
        end
        // Stray D$ response aimed at the waiting thread when there is one
        if (!sent && ($urandom % 6 == 0))
        begin
            mem_rsp.valid     = 1'b1;
            mem_rsp.cache_id  = 1'b1;
            mem_rsp.thread_id = outstanding ? pend_thread : thread_id_t'($urandom % 4);
            mem_rsp.data      = {4{32'hdead_beef}};
            foreign_count++;
        end
        if (icache_req_valid_miss)
        begin
            assert (!outstanding)
                else report_failure("New miss request while another was still outstanding");
            outstanding = 1'b1;
            pend_addr   = icache_req_info_miss.addr;
            pend_thread = icache_req_info_miss.thread_id;
            countdown   = 2 + ($urandom % 8);
        end
    endtask

    //////////////////////////////////////////////////
    // Per-cycle stimulus

    task automatic drive_controls();
        thread_id_t t;
        if (phase != last_phase)
            phase_cycles = 0;
        last_phase = phase;
        phase_cycles++;
        case (phase)
            2:
            begin
                redirect = '0;
                if ($urandom % 16 == 0)
                begin
                    redirect.branch_valid  = 1'b1;
                    redirect.branch_thread = thread_id_t'($urandom % 4);
                    redirect.branch_pc     = 32'h0001_0000 + (($urandom % 4096) << 2);
                end
            end
            3:
            begin
                redirect = '0;
                if ($urandom % 20 == 0)
                begin
                    t = thread_id_t'($urandom % 4);
                    redirect.xcpt_valid    = 1'b1;
                    redirect.xcpt_thread   = t;
                    // Same-thread branch half the time
                    redirect.branch_valid  = ($urandom % 4) != 0;
                    redirect.branch_thread = ($urandom % 2) ? t : thread_id_t'($urandom % 4);
                    redirect.branch_pc     = 32'h0001_8000 + (($urandom % 1024) << 2);
                end
            end
            4:
                ;
            default:
                redirect = '0;
        endcase
        if (phase == 5)
            stall = (phase_cycles <= 200) ? 4'b0100 : thread_mask_t'($urandom % 16);
        else
            stall = '0;
    endtask

    always @(posedge clock)
    begin
        #1;
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Run stopped after reaching the limit of %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
        else
        begin
            respond_memory();
            drive_controls();
        end
    end

    //////////////////////////////////////////////////
    // Checking against the model

    task automatic check_request();
        thread_id_t t;
        if (icache_req_valid_miss)
        begin
            t = icache_req_info_miss.thread_id;
            request_count++;
            assert (icache_req_info_miss.addr == exp_pc[t][31:4])
                else report_mismatch("miss line address", {exp_pc[t][31:4], 4'h0},
                                     {icache_req_info_miss.addr, 4'h0});
        end
    endtask

    task automatic check_output();
        thread_id_t t;
        if (decode_out.valid)
        begin
            t = decode_out.thread_id;
            output_count++;
            if (decode_out.xcpt)
            begin
                assert (err_expected[t] && !halted_model[t])
                    else report_failure($sformatf("Unexpected fetch exception on thread %0d", t));
                assert (decode_out.pc == exp_pc[t])
                    else report_mismatch("bus error pc", exp_pc[t], decode_out.pc);
                err_expected[t] = 1'b0;
                halted_model[t] = 1'b1;
                xcpt_seen[t]    = 1'b1;
            end
            else
            begin
                assert (!halted_model[t])
                    else report_failure($sformatf("Halted thread %0d produced an output", t));
                assert (!stall_prev[t])
                    else report_failure($sformatf("Stalled thread %0d produced an output", t));
                // First output after a redirect lands on its target
                if (redir_pending[t])
                begin
                    assert (decode_out.pc == redir_target[t])
                        else report_mismatch(redir_xcpt[t] ? "exception redirect" :
                                             "branch redirect", redir_target[t], decode_out.pc);
                    redir_pending[t] = 1'b0;
                end
                else
                begin
                    assert (decode_out.pc == exp_pc[t])
                        else report_mismatch("sequential pc", exp_pc[t], decode_out.pc);
                end
                // Memory word content is its own byte address
                assert (decode_out.instr == exp_pc[t])
                    else report_mismatch("instruction word", exp_pc[t], decode_out.instr);
                if (phase == 5 && stall_prev == 4'b0100)
                    window_outputs[t]++;
                exp_pc[t] = exp_pc[t] + 32'd4;
            end
        end
    endtask

    // Exception wins over a branch for the same thread
    task automatic apply_redirect();
        thread_id_t t;
        if (redirect.xcpt_valid)
        begin
            t                = redirect.xcpt_thread;
            exp_pc[t]        = `CORE_XCPT_ADDRESS;
            halted_model[t]  = 1'b0;
            redir_pending[t] = 1'b1;
            redir_xcpt[t]    = 1'b1;
            redir_target[t]  = `CORE_XCPT_ADDRESS;
        end
        if (redirect.branch_valid
            && !(redirect.xcpt_valid && redirect.xcpt_thread == redirect.branch_thread))
        begin
            t                = redirect.branch_thread;
            exp_pc[t]        = redirect.branch_pc;
            redir_pending[t] = 1'b1;
            redir_xcpt[t]    = 1'b0;
            redir_target[t]  = redirect.branch_pc;
        end
    endtask

    // Outputs settled half a cycle after the edge
    always @(negedge clock)
    begin
        if (!reset)
        begin
            check_request();
            check_output();
            apply_redirect();
            stall_prev = stall;
        end
    end

    //////////////////////////////////////////////////
    // Phase sequence

    task automatic pulse_redirect(input redirect_t value);
        @(posedge clock);
        #1;
        redirect = value;
        @(posedge clock);
        #1;
        redirect = '0;
    endtask

    initial
    begin
        redirect_t rd;

        void'($urandom(84));
        reset     = 1'b1;
        boot_addr = BOOT_PC;
        redirect  = '0;
        stall     = '0;
        mem_rsp   = '0;
        phase       = 0;
        last_phase  = 0;
        phase_cycles = 0;
        cycle_count = 0;
        error_count = 0;
        output_count = 0;
        request_count = 0;
        foreign_count = 0;
        outstanding = 1'b0;
        countdown   = 0;
        stall_prev  = '0;
        for (int i = 0; i < `THR_PER_CORE; i++)
        begin
            exp_pc[i]         = BOOT_PC;
            halted_model[i]   = 1'b0;
            err_expected[i]   = 1'b0;
            xcpt_seen[i]      = 1'b0;
            redir_pending[i]  = 1'b0;
            redir_xcpt[i]     = 1'b0;
            redir_target[i]   = '0;
            window_outputs[i] = 0;
        end

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        assert (!decode_out.valid && !icache_req_valid_miss)
            else report_failure("Outputs were active right after reset");

        // Free run, then branches, then exceptions
        phase = 1;
        repeat (400) @(posedge clock);
        phase = 2;
        repeat (400) @(posedge clock);
        phase = 3;
        repeat (400) @(posedge clock);

        // Bus-error lines for threads 1 and 3
        phase = 4;
        @(posedge clock);
        #1;
        redirect = '0;
        error_lines.push_back(28'h0004_000);
        error_lines.push_back(28'h0004_010);
        rd = '0;
        rd.branch_valid  = 1'b1;
        rd.branch_thread = 2'd1;
        rd.branch_pc     = 32'h0004_0008;
        pulse_redirect(rd);
        rd.branch_thread = 2'd3;
        rd.branch_pc     = 32'h0004_0104;
        pulse_redirect(rd);
        wait (xcpt_seen[1] && xcpt_seen[3]);
        // Halted threads must stay quiet here
        repeat (60) @(posedge clock);
        rd = '0;
        rd.xcpt_valid    = 1'b1;
        rd.xcpt_thread   = 2'd1;
        rd.branch_valid  = 1'b1;
        rd.branch_thread = 2'd1;
        rd.branch_pc     = 32'h0001_0040;
        pulse_redirect(rd);
        rd = '0;
        rd.xcpt_valid  = 1'b1;
        rd.xcpt_thread = 2'd3;
        pulse_redirect(rd);
        repeat (200) @(posedge clock);
        assert (!redir_pending[1] && !redir_pending[3])
            else report_failure("A thread gave no output after its exception redirect");

        // Thread 2 held, then random stall masks
        phase = 5;
        repeat (400) @(posedge clock);
        phase = 6;
        repeat (20) @(posedge clock);

        for (int i = 0; i < `THR_PER_CORE; i++)
            if (i != 2)
                assert (window_outputs[i] > 0)
                    else report_failure($sformatf("Thread %0d idle while thread 2 stalled", i));
        assert (request_count > 0 && foreign_count > 0)
            else report_failure("No miss request or no D$ response occurred");

        $display("Checks failed: %0d, outputs checked: %0d, miss requests: %0d, D$ responses: %0d",
                 error_count, output_count, request_count, foreign_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
